// ==== hdl/div_elem_issue.sv ====
`timescale 1ns/100ps

module div_elem_issue (
  input  logic              clk,
  input  logic              rst_n,
  input  vec_pkg::vec_req_t vec_in,
  input  logic              in_valid,
  output logic              in_ready,
  output div_pkg::div_req_t issue_req,
  output logic              issue_valid,
  input  logic              issue_ready
);
  import vec_pkg::*;
  import div_pkg::*;

  vec_req_t              inst_q;
  logic                  busy_q;
  logic [LANE_IDX_W-1:0] lane_q;
  div_op_e               op;
  logic                  last_lane;

  assign in_ready    = ~busy_q;
  assign issue_valid = busy_q;
  assign op          = div_op_e'(inst_q.op);
  assign last_lane   = (lane_q == LANE_IDX_W'(LANES - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      lane_q <= '0;
    end else if (in_valid && in_ready) begin
      busy_q <= 1'b1;
      lane_q <= '0;
    end else if (issue_valid && issue_ready) begin
      // free again once the final lane has gone out
      if (last_lane) begin
        busy_q <= 1'b0;
      end
      lane_q <= lane_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      inst_q <= vec_in;
    end
  end

  // element request for the current lane
  always_comb begin
    issue_req.sign         = (op == DIV_S || op == REM_S) ? DIV_SIGN : DIV_UNSIGN;
    issue_req.dividend     = inst_q.dividend[lane_q];
    issue_req.divisor      = inst_q.divisor[lane_q];
    issue_req.tag.lane     = lane_q;
    issue_req.tag.want_rem = (op == REM_U || op == REM_S);
    issue_req.tag.last     = last_lane;
  end

endmodule

// ==== hdl/div_pkg.sv ====
package div_pkg;

  import vec_pkg::ELEM_W;
  import vec_pkg::LANE_IDX_W;

  // bit 0 set for signed ops, bit 1 set for remainder ops
  typedef enum logic [1:0] {
    DIV_U = 2'd0,
    DIV_S = 2'd1,
    REM_U = 2'd2,
    REM_S = 2'd3
  } div_op_e;

  typedef enum logic {
    DIV_UNSIGN = 1'b0,
    DIV_SIGN   = 1'b1
  } div_sign_e;

  // carried through the divider unchanged
  typedef struct packed {
    logic [LANE_IDX_W-1:0] lane;
    logic                  want_rem;
    logic                  last;
  } div_tag_t;

  typedef struct packed {
    div_sign_e         sign;
    logic [ELEM_W-1:0] dividend;
    logic [ELEM_W-1:0] divisor;
    div_tag_t          tag;
  } div_req_t;

  typedef struct packed {
    logic [ELEM_W-1:0] quotient;
    logic [ELEM_W-1:0] remainder;
    div_tag_t          tag;
  } div_res_t;

endpackage

// ==== hdl/div_req_fifo.sv ====
`timescale 1ns/100ps

module div_req_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  div_pkg::div_req_t in_req,
  input  logic              in_valid,
  output logic              in_ready,
  output div_pkg::div_req_t out_req,
  output logic              out_valid,
  input  logic              out_ready
);
  import div_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  div_req_t         mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign in_ready  = (count_q != CNT_W'(FIFO_DEPTH));
  assign out_valid = (count_q != '0);
  assign out_req   = mem_q[rd_ptr_q];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_req;
    end
  end

endmodule

// ==== hdl/div_result_collect.sv ====
`timescale 1ns/100ps

module div_result_collect (
  input  logic              clk,
  input  logic              rst_n,
  input  div_pkg::div_res_t res,
  input  logic              res_valid,
  output logic              res_ready,
  output vec_pkg::vec_res_t vec_out,
  output logic              out_valid,
  input  logic              out_ready
);
  import vec_pkg::*;

  vec_res_t vec_q;
  logic     full_q;
  logic     take;

  // hold off the divider while a finished vector waits
  assign res_ready = ~full_q;
  assign out_valid = full_q;
  assign vec_out   = vec_q;
  assign take      = res_valid && res_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (take && res.tag.last) begin
      full_q <= 1'b1;
    end else if (out_valid && out_ready) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      vec_q.elem[res.tag.lane] <= res.tag.want_rem ? res.remainder : res.quotient;
    end
  end

endmodule

// ==== hdl/div_unit_divider.sv ====
`timescale 1ns/100ps

module div_unit_divider #(
  parameter int DIV_WIDTH = vec_pkg::ELEM_W
) (
  input  logic              clk,
  input  logic              rst_n,
  input  div_pkg::div_req_t req,
  input  logic              req_valid,
  output logic              req_ready,
  output div_pkg::div_res_t res,
  output logic              res_valid,
  input  logic              res_ready
);
  import div_pkg::*;

  localparam int LZ_W  = $clog2(DIV_WIDTH) + 1;
  localparam int CNT_W = $clog2(DIV_WIDTH + 2);
  localparam logic [DIV_WIDTH-1:0] MIN_NEG = {1'b1, {(DIV_WIDTH - 1){1'b0}}};

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WORK,
    ST_RESULT
  } state_e;

  state_e               state_q;
  state_e               state_d;

  // quotient register has one spare top bit so the first step shifts in a zero
  logic [DIV_WIDTH:0]   quot_q;
  logic [DIV_WIDTH-1:0] rem_q;
  logic [DIV_WIDTH-1:0] divisor_q;
  logic [CNT_W-1:0]     steps_q;
  logic                 q_neg_q;
  logic                 r_neg_q;
  div_tag_t             tag_q;

  logic                 sgn;
  logic                 a_neg;
  logic                 b_neg;
  logic [DIV_WIDTH-1:0] a_mag;
  logic [DIV_WIDTH-1:0] b_mag;
  logic [LZ_W-1:0]      lz;
  logic                 div_zero;
  logic                 overflow;

  logic [DIV_WIDTH:0]   q_nx;
  logic [DIV_WIDTH-1:0] r_nx;
  logic [DIV_WIDTH:0]   shifted;
  logic [CNT_W-1:0]     step_cnt;
  logic [CNT_W-1:0]     steps_left;

  // leading zeros by halving the search window each level
  function automatic logic [LZ_W-1:0] count_lz(input logic [DIV_WIDTH-1:0] v);
    logic [DIV_WIDTH-1:0] x;
    logic [LZ_W-1:0]      n;
    x = v;
    n = '0;
    if (v == '0) begin
      return LZ_W'(DIV_WIDTH);
    end
    for (int i = $clog2(DIV_WIDTH) - 1; i >= 0; i--) begin
      if ((x >> (DIV_WIDTH - (1 << i))) == '0) begin
        n = n + LZ_W'(1 << i);
        x = x << (1 << i);
      end
    end
    return n;
  endfunction

  // operand decode at acceptance
  always_comb begin
    sgn      = (req.sign == DIV_SIGN);
    a_neg    = sgn & req.dividend[DIV_WIDTH-1];
    b_neg    = sgn & req.divisor[DIV_WIDTH-1];
    a_mag    = a_neg ? (~req.dividend + 1'b1) : req.dividend;
    b_mag    = b_neg ? (~req.divisor + 1'b1) : req.divisor;
    lz       = count_lz(a_mag);
    div_zero = (req.divisor == '0);
    overflow = sgn && (req.dividend == MIN_NEG) && (req.divisor == '1);
  end

  // up to four shift-subtract steps per cycle
  always_comb begin
    q_nx       = quot_q;
    r_nx       = rem_q;
    shifted    = '0;
    step_cnt   = (steps_q > CNT_W'(4)) ? CNT_W'(4) : steps_q;
    steps_left = steps_q - step_cnt;
    for (int k = 0; k < 4; k++) begin
      if (CNT_W'(k) < steps_q) begin
        shifted = {r_nx, q_nx[DIV_WIDTH]};
        q_nx    = {q_nx[DIV_WIDTH-1:0], 1'b0};
        if (shifted >= {1'b0, divisor_q}) begin
          r_nx    = DIV_WIDTH'(shifted - {1'b0, divisor_q});
          q_nx[0] = 1'b1;
        end else begin
          r_nx = shifted[DIV_WIDTH-1:0];
        end
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (req_valid) begin
          state_d = (div_zero || overflow) ? ST_RESULT : ST_WORK;
        end
      end
      ST_WORK: begin
        if (steps_left == '0) begin
          state_d = ST_RESULT;
        end
      end
      ST_RESULT: begin
        if (res_ready) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      tag_q     <= req.tag;
      divisor_q <= b_mag;
      if (div_zero) begin
        quot_q  <= {1'b0, {DIV_WIDTH{1'b1}}};
        rem_q   <= req.dividend;
        q_neg_q <= 1'b0;
        r_neg_q <= 1'b0;
        steps_q <= '0;
      end else if (overflow) begin
        quot_q  <= {1'b0, MIN_NEG};
        rem_q   <= '0;
        q_neg_q <= 1'b0;
        r_neg_q <= 1'b0;
        steps_q <= '0;
      end else begin
        // normalize, then one step per significant bit plus the spare zero
        quot_q  <= {1'b0, a_mag} << lz;
        rem_q   <= '0;
        q_neg_q <= a_neg ^ b_neg;
        r_neg_q <= a_neg;
        steps_q <= CNT_W'(DIV_WIDTH + 1) - CNT_W'(lz);
      end
    end else if (state_q == ST_WORK) begin
      quot_q  <= q_nx;
      rem_q   <= r_nx;
      steps_q <= steps_left;
    end
  end

  assign req_ready = (state_q == ST_IDLE);
  assign res_valid = (state_q == ST_RESULT);

  // sign fix-up on the way out
  always_comb begin
    res.quotient  = q_neg_q ? (~quot_q[DIV_WIDTH-1:0] + 1'b1) : quot_q[DIV_WIDTH-1:0];
    res.remainder = r_neg_q ? (~rem_q + 1'b1) : rem_q;
    res.tag       = tag_q;
  end

endmodule

// ==== hdl/rvv_div_top.sv ====
`timescale 1ns/100ps

module rvv_div_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  vec_pkg::vec_req_t vec_in,
  input  logic              in_valid,
  output logic              in_ready,
  output vec_pkg::vec_res_t vec_out,
  output logic              out_valid,
  input  logic              out_ready
);
  import vec_pkg::*;
  import div_pkg::*;

  div_req_t issue_req;
  logic     issue_valid;
  logic     issue_ready;
  div_req_t div_req;
  logic     div_req_valid;
  logic     div_req_ready;
  div_res_t div_res;
  logic     div_res_valid;
  logic     div_res_ready;

  div_elem_issue u_issue (
    .clk         (clk),
    .rst_n       (rst_n),
    .vec_in      (vec_in),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .issue_req   (issue_req),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready)
  );

  div_req_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_req    (issue_req),
    .in_valid  (issue_valid),
    .in_ready  (issue_ready),
    .out_req   (div_req),
    .out_valid (div_req_valid),
    .out_ready (div_req_ready)
  );

  div_unit_divider #(
    .DIV_WIDTH (ELEM_W)
  ) u_divider (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (div_req),
    .req_valid (div_req_valid),
    .req_ready (div_req_ready),
    .res       (div_res),
    .res_valid (div_res_valid),
    .res_ready (div_res_ready)
  );

  div_result_collect u_collect (
    .clk       (clk),
    .rst_n     (rst_n),
    .res       (div_res),
    .res_valid (div_res_valid),
    .res_ready (div_res_ready),
    .vec_out   (vec_out),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

// ==== hdl/vec_pkg.sv ====
package vec_pkg;

  // vector shape
  localparam int ELEM_W     = 32;
  localparam int LANES      = 4;
  localparam int LANE_IDX_W = (LANES > 1) ? $clog2(LANES) : 1;

  // op holds a div_pkg::div_op_e code
  typedef struct packed {
    logic [1:0]                   op;
    logic [LANES-1:0][ELEM_W-1:0] dividend;
    logic [LANES-1:0][ELEM_W-1:0] divisor;
  } vec_req_t;

  typedef struct packed {
    logic [LANES-1:0][ELEM_W-1:0] elem;
  } vec_res_t;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module rvv_div_tb \
  -f sources.f --Mdir obj_dir -o rvv_div_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/rvv_div_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "Test OK" "$LOG"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0

// ==== sources.f ====
hdl/vec_pkg.sv
hdl/div_pkg.sv
hdl/div_elem_issue.sv
hdl/div_req_fifo.sv
hdl/div_unit_divider.sv
hdl/div_result_collect.sv
hdl/rvv_div_top.sv
tb/rvv_div_tb.sv

// ==== tb/rvv_div_tb.sv ====
`timescale 1ns/100ps

module rvv_div_tb;
  import vec_pkg::*;
  import div_pkg::*;

  localparam int IN_TIMEOUT    = 1000;
  localparam int DRAIN_TIMEOUT = 5000;
  localparam logic [ELEM_W-1:0] MIN_NEG = {1'b1, {(ELEM_W - 1){1'b0}}};

  logic        clk;
  logic        rst_n;
  vec_req_t    vec_in;
  logic        in_valid;
  logic        in_ready;
  vec_res_t    vec_out;
  logic        out_valid;
  logic        out_ready;

  logic        stall_en;
  logic [31:0] stim_seed;
  logic [31:0] stall_seed;
  logic [31:0] stall_word;
  int          errors;
  int          timeouts;
  int          sent;
  int          received;
  vec_res_t    exp_q[$];
  string       name_q[$];

  rvv_div_top #(
    .FIFO_DEPTH (4)
  ) DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .vec_in    (vec_in),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .vec_out   (vec_out),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next(inout logic [31:0] state);
    state = state * 32'd1103515245 + 32'd12345;
    return state;
  endfunction

  // low LCG bits cycle too fast so only upper halves are used
  function automatic logic [31:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next(stim_seed);
    lo = lcg_next(stim_seed);
    return {hi[31:16], lo[31:16]};
  endfunction

  // random significant width and sometimes negated
  function automatic logic [ELEM_W-1:0] rand_operand();
    logic [31:0]       r;
    logic [31:0]       sel;
    logic [ELEM_W-1:0] mask;
    logic [ELEM_W-1:0] v;
    int                bits;
    r    = rand_word();
    sel  = rand_word();
    bits = int'(sel[7:0]) % ELEM_W + 1;
    mask = (bits >= ELEM_W) ? '1 : ((ELEM_W'(1) << bits) - ELEM_W'(1));
    v    = ELEM_W'(r) & mask;
    if (sel[8]) begin
      v = ~v + ELEM_W'(1);
    end
    return v;
  endfunction

  function automatic vec_req_t rand_vec(input div_op_e op);
    vec_req_t v;
    v.op = op;
    for (int i = 0; i < LANES; i++) begin
      v.dividend[i] = rand_operand();
      v.divisor[i]  = rand_operand();
    end
    return v;
  endfunction

  function automatic void edge_pair(input int k, output logic [ELEM_W-1:0] a,
                                    output logic [ELEM_W-1:0] b);
    case (k % 8)
      0: {a, b} = {ELEM_W'(0), ELEM_W'(7)};
      1: {a, b} = {rand_operand(), ELEM_W'(1)};
      2: {a, b} = {ELEM_W'(3), ELEM_W'(100)};
      3: {a, b} = {{ELEM_W{1'b1}}, {ELEM_W{1'b1}}};
      4: {a, b} = {{ELEM_W{1'b1}}, ELEM_W'(1)};
      5: {a, b} = {{ELEM_W{1'b1}}, ELEM_W'(2)};
      6: {a, b} = {ELEM_W'(100), {ELEM_W{1'b1}}};
      default: {a, b} = {MIN_NEG, ELEM_W'(1)};
    endcase
  endfunction

  // truncating division with the remainder taking the dividend sign
  function automatic logic [ELEM_W-1:0] model_elem(input div_op_e op,
                                                   input logic [ELEM_W-1:0] a,
                                                   input logic [ELEM_W-1:0] b);
    logic              sgn;
    logic [ELEM_W-1:0] q;
    logic [ELEM_W-1:0] r;
    sgn = (op == DIV_S || op == REM_S);
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (sgn && a == MIN_NEG && b == '1) begin
      q = MIN_NEG;
      r = '0;
    end else if (sgn) begin
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      r = a % b;
    end
    return (op == REM_U || op == REM_S) ? r : q;
  endfunction

  function automatic vec_res_t model_vec(input vec_req_t v);
    vec_res_t e;
    for (int i = 0; i < LANES; i++) begin
      e.elem[i] = model_elem(div_op_e'(v.op), v.dividend[i], v.divisor[i]);
    end
    return e;
  endfunction

  task automatic check_vec_res(input string name, input vec_res_t exp_v, input vec_res_t act_v);
    if (act_v !== exp_v) begin
      errors++;
      $display("ERROR %s: expected %h actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic check_flag(input string name, input logic exp_b, input logic act_b);
    if (act_b !== exp_b) begin
      errors++;
      $display("ERROR %s: expected %b actual %b", name, exp_b, act_b);
    end
  endtask

  task automatic end_run();
    $display("errors %0d, timeouts %0d, vectors sent %0d, vectors received %0d",
             errors, timeouts, sent, received);
    if (errors == 0 && timeouts == 0 && sent == received) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  // starts on a falling edge and returns on the one after the transfer
  task automatic send_vec(input string name, input vec_req_t v);
    int waited;
    // nothing more goes in once the input has stalled
    if (timeouts != 0) begin
      return;
    end
    waited   = 0;
    vec_in   = v;
    in_valid = 1'b1;
    while (!in_ready && waited < IN_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!in_ready) begin
      $display("timeout: in_ready stayed low for %0d cycles in %s", waited, name);
      timeouts++;
    end else begin
      @(negedge clk);
      in_valid = 1'b0;
      exp_q.push_back(model_vec(v));
      name_q.push_back(name);
      sent++;
    end
  endtask

  // out_ready drawn and outputs checked on each falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      stall_word = lcg_next(stall_seed);
      out_ready  = stall_en ? (stall_word[31:30] != 2'b00) : 1'b1;
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("output vector arrived with no instruction outstanding");
        end else begin
          check_vec_res(name_q.pop_front(), exp_q.pop_front(), vec_out);
          received++;
        end
      end
    end
  end

  initial begin
    vec_req_t          v;
    logic [31:0]       r;
    logic [ELEM_W-1:0] a;
    logic [ELEM_W-1:0] b;
    int                waited;
    clk        = 1'b0;
    rst_n      = 1'b0;
    vec_in     = '0;
    in_valid   = 1'b0;
    out_ready  = 1'b0;
    stall_en   = 1'b0;
    stim_seed  = 32'd92130;
    stall_seed = 32'd92130;
    errors     = 0;
    timeouts   = 0;
    sent       = 0;
    received   = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_flag("reset in_ready", 1'b1, in_ready);
    check_flag("reset out_valid", 1'b0, out_valid);

    for (int n = 0; n < 40; n++) begin
      r = rand_word();
      send_vec("random", rand_vec(div_op_e'(r[1:0])));
    end

    for (int k = 0; k < 4; k++) begin
      v = rand_vec(div_op_e'(2'(k)));
      v.divisor[k % LANES]       = '0;
      v.divisor[(k + 2) % LANES] = '0;
      send_vec("div_zero", v);
    end

    // odd lanes see the same dividend with other divisors
    for (int k = 0; k < 4; k++) begin
      v = rand_vec(div_op_e'(2'(k)));
      for (int i = 0; i < LANES; i++) begin
        v.dividend[i] = MIN_NEG;
        if (i % 2 == 0) begin
          v.divisor[i] = '1;
        end
      end
      send_vec("overflow", v);
    end

    for (int k = 0; k < 4; k++) begin
      for (int base = 0; base < 8; base += LANES) begin
        v.op = 2'(k);
        for (int i = 0; i < LANES; i++) begin
          edge_pair(base + i, a, b);
          v.dividend[i] = a;
          v.divisor[i]  = b;
        end
        send_vec("edge", v);
      end
    end

    stall_en = 1'b1;
    for (int n = 0; n < 40; n++) begin
      r = rand_word();
      send_vec("stall", rand_vec(div_op_e'(r[1:0])));
    end

    waited = 0;
    while (received < sent && waited < DRAIN_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (received < sent) begin
      $display("timeout: out_valid never delivered %0d outstanding vectors", sent - received);
      timeouts++;
    end
    // quiet period to catch duplicate outputs
    repeat (20) @(negedge clk);
    end_run();
  end

endmodule
